// File: Bender.yml
package:
  name: exec_top

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv_op_pkg.sv
      - logic/stage_pkg.sv
      - logic/pipe_reg.sv
      - logic/imm_unit.sv
      - logic/alu.sv
      - logic/exec_unit.sv
      - logic/exec_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/exec_checker.sv
      - test/exec_top_tb.sv

// File: exec_top.f
+incdir+logic
logic/rv_op_pkg.sv
logic/stage_pkg.sv
logic/pipe_reg.sv
logic/imm_unit.sv
logic/alu.sv
logic/exec_unit.sv
logic/exec_top.sv
test/exec_checker.sv
test/exec_top_tb.sv

// File: logic/alu.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module alu (
    input  rv_op_pkg::alu_op_t    op,
    input  logic [`EXEC_XLEN-1:0] a,
    input  logic [`EXEC_XLEN-1:0] b,
    output logic [`EXEC_XLEN-1:0] y
);

    logic [`EXEC_SHAMT_W-1:0] shamt;
    logic                     lt_signed;
    logic                     lt_unsigned;

    assign shamt       = b[`EXEC_SHAMT_W-1:0]; // upper bits of b ignored.
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            rv_op_pkg::add: begin
                y = a + b;
            end
            rv_op_pkg::sub: begin
                y = a - b;
            end
            rv_op_pkg::sll: begin
                y = a << shamt;
            end
            rv_op_pkg::slt: begin
                y = {{(`EXEC_XLEN-1){1'b0}}, lt_signed};
            end
            rv_op_pkg::sltu: begin
                y = {{(`EXEC_XLEN-1){1'b0}}, lt_unsigned};
            end
            rv_op_pkg::xor_op: begin
                y = a ^ b;
            end
            rv_op_pkg::srl: begin
                y = a >> shamt;
            end
            rv_op_pkg::sra: begin
                y = $unsigned($signed(a) >>> shamt);
            end
            rv_op_pkg::or_op: begin
                y = a | b;
            end
            rv_op_pkg::and_op: begin
                y = a & b;
            end
            default: begin
                y = '0; // codes 10 to 15.
            end
        endcase
    end

endmodule

// File: logic/exec_defs.svh
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// datapath and register index.
`define EXEC_XLEN       32
`define EXEC_REG_W      5
`define EXEC_SHAMT_W    5

// instruction and control field widths.
`define EXEC_FUNCT3_W   3
`define EXEC_ALU_OP_W   4
`define EXEC_IMM_KIND_W 2
`define EXEC_SRC_W      2
`define EXEC_CSR_WEN_W  4

`endif

// File: logic/exec_top.sv
`timescale 1ns/1ps

module exec_top (
    input  logic               clock,
    input  logic               reset,
    input  logic               flush,

    input  logic               in_valid,
    output logic               in_ready,
    input  stage_pkg::issue_t  in_bundle,

    output logic               out_valid,
    input  logic               out_ready,
    output stage_pkg::result_t out_bundle
);

    logic               issue_valid;
    logic               issue_ready; // back-pressure from the result slot.
    stage_pkg::issue_t  issue_q;
    stage_pkg::result_t exec_result;

    pipe_reg #(
        .payload_t (stage_pkg::issue_t)
    ) issue_reg (
        .clock     (clock),
        .reset     (reset),
        .flush     (flush),
        .valid_in  (in_valid),
        .ready_in  (in_ready),
        .data_in   (in_bundle),
        .valid_out (issue_valid),
        .ready_out (issue_ready),
        .data_out  (issue_q)
    );

    exec_unit exec_unit_inst (
        .issue_valid (issue_valid),
        .issue       (issue_q),
        .result      (exec_result)
    );

    pipe_reg #(
        .payload_t (stage_pkg::result_t)
    ) result_reg (
        .clock     (clock),
        .reset     (reset),
        .flush     (flush),
        .valid_in  (issue_valid),
        .ready_in  (issue_ready),
        .data_in   (exec_result),
        .valid_out (out_valid),
        .ready_out (out_ready),
        .data_out  (out_bundle)
    );

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_unit (
    input  logic               issue_valid,
    input  stage_pkg::issue_t  issue,
    output stage_pkg::result_t result
);

    logic [`EXEC_XLEN-1:0] imm_value;
    logic [`EXEC_XLEN-1:0] operand_a;
    logic [`EXEC_XLEN-1:0] operand_b;
    logic [`EXEC_XLEN-1:0] alu_y;

    imm_unit imm_unit_inst (
        .imm       (issue.imm),
        .kind      (issue.imm_kind),
        .imm_value (imm_value)
    );

    always_comb begin
        case (issue.src_a)
            rv_op_pkg::src_a_rs1: operand_a = issue.rs1_value;
            rv_op_pkg::src_a_pc:  operand_a = issue.pc;
            default:              operand_a = '0; // zero and the spare code.
        endcase
    end

    always_comb begin
        case (issue.src_b)
            rv_op_pkg::src_b_imm: operand_b = imm_value;
            rv_op_pkg::src_b_rs2: operand_b = issue.rs2_value;
            rv_op_pkg::src_b_csr: operand_b = issue.csr_value;
            default:              operand_b = '0;
        endcase
    end

    alu alu_inst (
        .op (issue.alu_op),
        .a  (operand_a),
        .b  (operand_b),
        .y  (alu_y)
    );

    always_comb begin
        result            = '0;
        result.pc         = issue.pc;
        result.inst       = issue.inst;
        result.rd         = issue.rd;
        result.funct3     = issue.funct3;
        // bge and bgeu reuse the slt compare with bit 0 flipped.
        result.result     = alu_y ^ {{(`EXEC_XLEN-1){1'b0}}, issue.inv};
        result.store_data = issue.rs2_value;
        result.imm        = issue.imm;
        result.csr_value  = issue.csr_value;
        result.reg_wen    = issue.reg_wen;
        result.mem_wen    = issue.mem_wen;
        result.mem_ren    = issue.mem_ren;
        result.csr_wen    = issue.csr_wen;
        result.jump       = issue.jump;
        result.branch     = issue.branch;
    end

    // decode must only hand over codes the alu knows.
    always_comb begin
        if (issue_valid) begin
            alu_op_legal: assert final ($unsigned(issue.alu_op) <= $unsigned(rv_op_pkg::and_op));
        end
    end

endmodule

// File: logic/imm_unit.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module imm_unit (
    input  logic [`EXEC_XLEN-1:0] imm,
    input  rv_op_pkg::imm_kind_t  kind,
    output logic [`EXEC_XLEN-1:0] imm_value
);

    localparam int I12_W = 12;
    localparam int U20_W = 20;
    localparam int U5_W  = 5;

    always_comb begin
        case (kind)
            rv_op_pkg::imm_i12:
                imm_value = {{(`EXEC_XLEN-I12_W){imm[I12_W-1]}}, imm[I12_W-1:0]};
            rv_op_pkg::imm_u20:
                imm_value = {imm[U20_W-1:0], {(`EXEC_XLEN-U20_W){1'b0}}};
            rv_op_pkg::imm_j20:
                // sign extend, then one place left.
                imm_value = {{(`EXEC_XLEN-U20_W-1){imm[U20_W-1]}}, imm[U20_W-1:0], 1'b0};
            rv_op_pkg::imm_u5:
                imm_value = {{(`EXEC_XLEN-U5_W){1'b0}}, imm[U5_W-1:0]};
            default:
                imm_value = '0;
        endcase
    end

endmodule

// File: logic/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     flush,

    input  logic     valid_in,
    output logic     ready_in,
    input  payload_t data_in,

    output logic     valid_out,
    input  logic     ready_out,
    output payload_t data_out
);

    logic     valid_q;
    payload_t data_q;

    // a full slot still accepts when it drains in the same cycle.
    assign ready_in = !valid_q || ready_out;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0; // drops the held item and the one on offer.
        end else if (ready_in) begin
            valid_q <= valid_in;
        end
    end

    always_ff @(posedge clock) begin
        if (valid_in && ready_in) begin
            data_q <= data_in;
        end
    end

    assign valid_out = valid_q;
    assign data_out  = data_q;

    // a stalled item must not change under the consumer.
    stall_holds_data: assert property (
        @(posedge clock) disable iff (reset)
        valid_out && !ready_out && !flush |=> valid_out && $stable(data_out)
    );

    valid_known: assert property (
        @(posedge clock) disable iff (reset)
        !$isunknown(valid_out)
    );

endmodule

// File: logic/rv_op_pkg.sv
`include "exec_defs.svh"

package rv_op_pkg;

    // alu operation, dense from zero.
    typedef enum logic [`EXEC_ALU_OP_W-1:0] {
        add    = 4'd0,
        sub    = 4'd1,
        sll    = 4'd2,
        slt    = 4'd3,
        sltu   = 4'd4,
        xor_op = 4'd5,
        srl    = 4'd6,
        sra    = 4'd7,
        or_op  = 4'd8,
        and_op = 4'd9
    } alu_op_t;

    // how the raw immediate field is widened.
    typedef enum logic [`EXEC_IMM_KIND_W-1:0] {
        imm_i12 = 2'd0, // signed 12 bit.
        imm_u20 = 2'd1, // upper immediate.
        imm_j20 = 2'd2, // jump offset, halfword units.
        imm_u5  = 2'd3  // shift amount or csr zimm.
    } imm_kind_t;

    // operand a, code 3 also reads as zero.
    typedef enum logic [`EXEC_SRC_W-1:0] {
        src_a_rs1  = 2'd0,
        src_a_pc   = 2'd1,
        src_a_zero = 2'd2
    } src_a_t;

    typedef enum logic [`EXEC_SRC_W-1:0] {
        src_b_imm  = 2'd0,
        src_b_rs2  = 2'd1,
        src_b_csr  = 2'd2,
        src_b_zero = 2'd3
    } src_b_t;

endpackage

// File: logic/stage_pkg.sv
`include "exec_defs.svh"

package stage_pkg;

    // decoded instruction as it enters execute.
    typedef struct packed {
        logic [`EXEC_XLEN-1:0]      pc;
        logic [`EXEC_XLEN-1:0]      inst;
        logic [`EXEC_REG_W-1:0]     rd;
        logic [`EXEC_FUNCT3_W-1:0]  funct3;
        logic [`EXEC_XLEN-1:0]      imm;        // raw field from decode.
        rv_op_pkg::imm_kind_t       imm_kind;
        rv_op_pkg::alu_op_t         alu_op;
        logic                       inv;        // flip bit 0 of the result.
        rv_op_pkg::src_a_t          src_a;
        rv_op_pkg::src_b_t          src_b;
        logic [`EXEC_XLEN-1:0]      rs1_value;
        logic [`EXEC_XLEN-1:0]      rs2_value;
        logic [`EXEC_XLEN-1:0]      csr_value;
        logic                       reg_wen;
        logic                       mem_wen;
        logic                       mem_ren;
        logic [`EXEC_CSR_WEN_W-1:0] csr_wen;
        logic                       jump;
        logic                       branch;
    } issue_t;

    // what the memory stage gets.
    typedef struct packed {
        logic [`EXEC_XLEN-1:0]      pc;
        logic [`EXEC_XLEN-1:0]      inst;
        logic [`EXEC_REG_W-1:0]     rd;
        logic [`EXEC_FUNCT3_W-1:0]  funct3;
        logic [`EXEC_XLEN-1:0]      result;
        logic [`EXEC_XLEN-1:0]      store_data;
        logic [`EXEC_XLEN-1:0]      imm;        // still the raw field.
        logic [`EXEC_XLEN-1:0]      csr_value;
        logic                       reg_wen;
        logic                       mem_wen;
        logic                       mem_ren;
        logic [`EXEC_CSR_WEN_W-1:0] csr_wen;
        logic                       jump;
        logic                       branch;
    } result_t;

endpackage

// File: test/exec_checker.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_checker (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  in_valid,
    input  logic                  in_ready,
    input  stage_pkg::issue_t     in_bundle,
    input  logic [`EXEC_XLEN-1:0] expected_result,
    input  logic                  out_valid,
    input  logic                  out_ready,
    input  stage_pkg::result_t    out_bundle,
    output int                    error_count,
    output int                    pending
);

    stage_pkg::result_t expect_q [$];
    stage_pkg::result_t held_bundle;
    logic               stalled;

    // every field passes through, only result is computed.
    function automatic stage_pkg::result_t expected_from(
        input stage_pkg::issue_t     issue,
        input logic [`EXEC_XLEN-1:0] value
    );
        stage_pkg::result_t want;
        want            = '0;
        want.pc         = issue.pc;
        want.inst       = issue.inst;
        want.rd         = issue.rd;
        want.funct3     = issue.funct3;
        want.result     = value;
        want.store_data = issue.rs2_value;
        want.imm        = issue.imm; // raw field, not the formed one.
        want.csr_value  = issue.csr_value;
        want.reg_wen    = issue.reg_wen;
        want.mem_wen    = issue.mem_wen;
        want.mem_ren    = issue.mem_ren;
        want.csr_wen    = issue.csr_wen;
        want.jump       = issue.jump;
        want.branch     = issue.branch;
        return want;
    endfunction

    task automatic compare_field(
        input string                 name,
        input logic [`EXEC_XLEN-1:0] want,
        input logic [`EXEC_XLEN-1:0] got
    );
        if (got !== want) begin
            $display("Error: out_bundle.%s expected %h actual %h", name, want, got);
            error_count++;
        end
    endtask

    task automatic compare_bundle(input stage_pkg::result_t want, input stage_pkg::result_t got);
        compare_field("pc", want.pc, got.pc);
        compare_field("inst", want.inst, got.inst);
        compare_field("rd", want.rd, got.rd);
        compare_field("funct3", want.funct3, got.funct3);
        compare_field("result", want.result, got.result);
        compare_field("store_data", want.store_data, got.store_data);
        compare_field("imm", want.imm, got.imm);
        compare_field("csr_value", want.csr_value, got.csr_value);
        compare_field("reg_wen", want.reg_wen, got.reg_wen);
        compare_field("mem_wen", want.mem_wen, got.mem_wen);
        compare_field("mem_ren", want.mem_ren, got.mem_ren);
        compare_field("csr_wen", want.csr_wen, got.csr_wen);
        compare_field("jump", want.jump, got.jump);
        compare_field("branch", want.branch, got.branch);
    endtask

    initial begin
        error_count = 0;
        pending     = 0;
        stalled     = 1'b0;
    end

    always @(posedge clock) begin
        if (reset) begin
            expect_q.delete();
            stalled = 1'b0;
        end else begin
            // a stalled output must still be there, unchanged.
            if (stalled && out_valid !== 1'b1) begin
                $display("Error: out_valid expected 1 actual %h during a stall", out_valid);
                error_count++;
            end else if (stalled && out_bundle !== held_bundle) begin
                $display("Error: out_bundle changed during a stall, expected %h actual %h",
                         held_bundle, out_bundle);
                error_count++;
            end
            stalled     = out_valid && !out_ready && !flush;
            held_bundle = out_bundle;
            if (flush) begin
                expect_q.delete(); // in flight and on offer, all gone.
            end else begin
                if (out_valid && out_ready) begin
                    if (expect_q.size() == 0) begin
                        $display("an item came out although none was expected");
                        error_count++;
                    end else begin
                        compare_bundle(expect_q.pop_front(), out_bundle);
                    end
                end
                if (in_valid && in_ready) begin
                    expect_q.push_back(expected_from(in_bundle, expected_result));
                end
            end
        end
        pending = expect_q.size();
    end

endmodule

// File: test/exec_top_tb.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_top_tb;

    localparam int NUM_ROWS       = 28;
    localparam int TIMEOUT_CYCLES = 20 * NUM_ROWS + 50;

    // flush marks a row offered together with a flush.
    typedef struct packed {
        stage_pkg::issue_t     issue;
        logic [`EXEC_XLEN-1:0] expected;
        logic                  flush;
    } row_t;

    logic                  clock;
    logic                  reset;
    logic                  flush;
    logic                  in_valid;
    logic                  in_ready;
    stage_pkg::issue_t     in_bundle;
    logic                  out_valid;
    logic                  out_ready;
    stage_pkg::result_t    out_bundle;
    logic [`EXEC_XLEN-1:0] expected_result;

    row_t rows [NUM_ROWS];
    int   row_count;
    int   seed;
    logic hold_ready;
    int   tb_errors;
    int   error_count;
    int   pending;
    int   cycles;
    int   edges;
    int   drain;
    logic seen;

    exec_top exec_top_inst (
        .clock      (clock),
        .reset      (reset),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_bundle  (in_bundle),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_bundle (out_bundle)
    );

    exec_checker exec_checker_inst (
        .clock           (clock),
        .reset           (reset),
        .flush           (flush),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_bundle       (in_bundle),
        .expected_result (expected_result),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_bundle      (out_bundle),
        .error_count     (error_count),
        .pending         (pending)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout after %0d cycles, the run never reached its end", cycles);
        $display("tests failed");
        $finish;
    end

    // sink is ready about 70 percent of the time.
    initial begin
        forever begin
            @(posedge clock);
            #1;
            out_ready = hold_ready ? 1'b1 : (($unsigned($random(seed)) % 10) < 7);
        end
    end

    task automatic add_row(
        input rv_op_pkg::alu_op_t    op,
        input logic                  inv,
        input rv_op_pkg::src_a_t     src_a,
        input rv_op_pkg::src_b_t     src_b,
        input rv_op_pkg::imm_kind_t  kind,
        input logic [`EXEC_XLEN-1:0] imm,
        input logic [`EXEC_XLEN-1:0] rs1,
        input logic [`EXEC_XLEN-1:0] rs2,
        input logic [`EXEC_XLEN-1:0] csr,
        input logic [`EXEC_XLEN-1:0] expected,
        input logic                  flush_row
    );
        row_t       row;
        logic [4:0] idx;
        idx                 = row_count[4:0];
        row                 = '0;
        row.issue.pc        = 32'h0001_0000 + row_count * 4; // pc of row n is base + 4n.
        row.issue.inst      = 32'h0000_0033 | (row_count << 20);
        row.issue.rd        = idx + 5'd1;
        row.issue.funct3    = idx[2:0];
        row.issue.imm       = imm;
        row.issue.imm_kind  = kind;
        row.issue.alu_op    = op;
        row.issue.inv       = inv;
        row.issue.src_a     = src_a;
        row.issue.src_b     = src_b;
        row.issue.rs1_value = rs1;
        row.issue.rs2_value = rs2;
        row.issue.csr_value = csr;
        // flags follow the row index so each one toggles.
        row.issue.reg_wen   = idx[0];
        row.issue.mem_wen   = idx[1];
        row.issue.mem_ren   = idx[2];
        row.issue.csr_wen   = idx[3:0] ^ 4'ha;
        row.issue.jump      = idx[3];
        row.issue.branch    = idx[4];
        row.expected        = expected;
        row.flush           = flush_row;
        rows[row_count]     = row;
        row_count++;
    endtask

    task automatic build_table();
        row_count = 0;
        add_row(rv_op_pkg::add, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_rs2, rv_op_pkg::imm_i12,
                32'h0, 32'h0000_1234, 32'h0000_0ff0, 32'h0000_0300, 32'h0000_2224, 1'b0);
        add_row(rv_op_pkg::sub, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_rs2, rv_op_pkg::imm_i12,
                32'h0, 32'h0000_0010, 32'h0000_0020, 32'h0000_0301, 32'hffff_fff0, 1'b0);
        add_row(rv_op_pkg::sll, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_rs2, rv_op_pkg::imm_i12,
                32'h0, 32'h0000_0003, 32'hffff_ffe4, 32'h0000_0302, 32'h0000_0030, 1'b0);
        add_row(rv_op_pkg::slt, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_rs2, rv_op_pkg::imm_i12,
                32'h0, 32'h8000_0000, 32'h0000_0001, 32'h0000_0303, 32'h0000_0001, 1'b0);
        add_row(rv_op_pkg::sltu, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_rs2, rv_op_pkg::imm_i12,
                32'h0, 32'h8000_0000, 32'h0000_0001, 32'h0000_0304, 32'h0000_0000, 1'b0);
        add_row(rv_op_pkg::xor_op, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_rs2, rv_op_pkg::imm_i12,
                32'h0, 32'ha5a5_a5a5, 32'h0f0f_0f0f, 32'h0000_0305, 32'haaaa_aaaa, 1'b0);
        add_row(rv_op_pkg::srl, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_rs2, rv_op_pkg::imm_i12,
                32'h0, 32'h8000_00f0, 32'h0000_0004, 32'h0000_0306, 32'h0800_000f, 1'b0);
        add_row(rv_op_pkg::sra, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_rs2, rv_op_pkg::imm_i12,
                32'h0, 32'h8000_00f0, 32'h0000_0004, 32'h0000_0307, 32'hf800_000f, 1'b0);
        add_row(rv_op_pkg::or_op, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_rs2, rv_op_pkg::imm_i12,
                32'h0, 32'h1200_0034, 32'h0056_7800, 32'h0000_0308, 32'h1256_7834, 1'b0);
        add_row(rv_op_pkg::and_op, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_rs2, rv_op_pkg::imm_i12,
                32'h0, 32'hff00_ff00, 32'h0ff0_0ff0, 32'h0000_0309, 32'h0f00_0f00, 1'b0);
        // fillers that the following flush drops.
        add_row(rv_op_pkg::sub, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_rs2, rv_op_pkg::imm_i12,
                32'h0, 32'h0000_0050, 32'h0000_0008, 32'h0000_0320, 32'h0000_0048, 1'b0);
        add_row(rv_op_pkg::and_op, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_rs2, rv_op_pkg::imm_i12,
                32'h0, 32'h0000_f0f0, 32'h0000_0ff0, 32'h0000_0321, 32'h0000_00f0, 1'b0);
        add_row(rv_op_pkg::add, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_rs2, rv_op_pkg::imm_i12,
                32'h0, 32'h0000_0001, 32'h0000_0001, 32'h0000_030a, 32'h0000_0002, 1'b1);
        add_row(rv_op_pkg::add, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_imm, rv_op_pkg::imm_i12,
                32'h1230_0ff8, 32'h0000_0100, 32'h0, 32'h0000_030b, 32'h0000_00f8, 1'b0);
        add_row(rv_op_pkg::add, 1'b0, rv_op_pkg::src_a_pc, rv_op_pkg::src_b_imm, rv_op_pkg::imm_u20,
                32'h0001_2345, 32'h0, 32'h0, 32'h0000_030c, 32'h1235_5038, 1'b0);
        add_row(rv_op_pkg::add, 1'b0, rv_op_pkg::src_a_t'(2'd3), rv_op_pkg::src_b_imm,
                rv_op_pkg::imm_u20, 32'hfff8_0001, 32'h5555_5555, 32'h0, 32'h0000_030d,
                32'h8000_1000, 1'b0);
        add_row(rv_op_pkg::add, 1'b0, rv_op_pkg::src_a_pc, rv_op_pkg::src_b_imm, rv_op_pkg::imm_j20,
                32'h000f_fffe, 32'h0, 32'h0, 32'h0000_030e, 32'h0001_003c, 1'b0);
        add_row(rv_op_pkg::add, 1'b0, rv_op_pkg::src_a_zero, rv_op_pkg::src_b_imm, rv_op_pkg::imm_u5,
                32'hffff_ffed, 32'h7777_7777, 32'h0, 32'h0000_030f, 32'h0000_000d, 1'b0);
        add_row(rv_op_pkg::or_op, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_csr, rv_op_pkg::imm_i12,
                32'h0, 32'h0000_00f0, 32'h0000_0abc, 32'h0000_0f0f, 32'h0000_0fff, 1'b0);
        add_row(rv_op_pkg::add, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_zero, rv_op_pkg::imm_i12,
                32'h0000_0123, 32'hdead_beef, 32'h0, 32'h0000_0311, 32'hdead_beef, 1'b0);
        add_row(rv_op_pkg::add, 1'b0, rv_op_pkg::src_a_zero, rv_op_pkg::src_b_rs2, rv_op_pkg::imm_i12,
                32'h0, 32'h1111_1111, 32'h0000_0777, 32'h0000_0312, 32'h0000_0777, 1'b0);
        // inverted compares as bge and bgeu use them.
        add_row(rv_op_pkg::slt, 1'b1, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_rs2, rv_op_pkg::imm_i12,
                32'h0, 32'h0000_0005, 32'h0000_0003, 32'h0000_0313, 32'h0000_0001, 1'b0);
        add_row(rv_op_pkg::sltu, 1'b1, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_rs2, rv_op_pkg::imm_i12,
                32'h0, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0314, 32'h0000_0000, 1'b0);
        add_row(rv_op_pkg::or_op, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_rs2, rv_op_pkg::imm_i12,
                32'h0, 32'h0000_0001, 32'h0000_0002, 32'h0000_0322, 32'h0000_0003, 1'b0);
        add_row(rv_op_pkg::add, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_rs2, rv_op_pkg::imm_i12,
                32'h0, 32'h0000_0007, 32'h0000_0009, 32'h0000_0323, 32'h0000_0010, 1'b0);
        add_row(rv_op_pkg::xor_op, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_rs2, rv_op_pkg::imm_i12,
                32'h0, 32'h0000_0001, 32'h0000_0003, 32'h0000_0315, 32'h0000_0002, 1'b1);
        add_row(rv_op_pkg::add, 1'b1, rv_op_pkg::src_a_pc, rv_op_pkg::src_b_imm, rv_op_pkg::imm_u5,
                32'h0000_0004, 32'h0, 32'h0, 32'h0000_0316, 32'h0001_006d, 1'b0);
        add_row(rv_op_pkg::srl, 1'b0, rv_op_pkg::src_a_rs1, rv_op_pkg::src_b_imm, rv_op_pkg::imm_u5,
                32'h0000_0fe4, 32'hf000_0000, 32'h0, 32'h0000_0317, 32'h0f00_0000, 1'b0);
    endtask

    task automatic expect_level(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            tb_errors++;
        end
    endtask

    // starts and ends 1 ns after an edge and holds the offer until taken or flushed.
    task automatic offer_row(input int i);
        logic taken;
        in_valid        = 1'b1;
        in_bundle       = rows[i].issue;
        expected_result = rows[i].expected;
        flush           = rows[i].flush;
        taken           = 1'b0;
        while (!taken) begin
            #2;
            taken = in_ready || rows[i].flush;
            @(posedge clock);
            #1;
        end
        in_valid = 1'b0;
        flush    = 1'b0;
    endtask

    initial begin
        reset           = 1'b1;
        flush           = 1'b0;
        in_valid        = 1'b0;
        in_bundle       = '0;
        expected_result = '0;
        out_ready       = 1'b0;
        hold_ready      = 1'b1;
        seed            = 32'h5f72_2366;
        tb_errors       = 0;
        build_table();
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
        #2;
        expect_level("out_valid", out_valid, 1'b0);
        expect_level("in_ready", in_ready, 1'b1);
        @(posedge clock);
        #1;

        // lone item with the sink always ready.
        offer_row(0);
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges < 8) begin
            #2;
            seen = out_valid && out_ready;
            @(posedge clock);
            #1;
            edges++;
        end
        if (!seen) begin
            $display("the first item never left the stage");
            tb_errors++;
        end else if (edges != 2) begin
            $display("Error: latency expected %h actual %h", 2, edges);
            tb_errors++;
        end

        hold_ready = 1'b0;
        for (int i = 1; i < NUM_ROWS; i++) begin
            offer_row(i);
        end
        drain = 0;
        while (pending != 0 && drain < 100) begin
            @(posedge clock);
            #1;
            drain++;
        end
        if (pending != 0) begin
            $display("%0d accepted items never came out of the stage", pending);
            tb_errors++;
        end

        $display("errors: %0d from the checker, %0d from the testbench", error_count, tb_errors);
        if (error_count == 0 && tb_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
